// File: rtl/srt_digit_select.sv
// radix-4 quotient digit selection from divisor and partial remainder top bits
`timescale 1ns/1ps

module srt_digit_select (
    input  logic [2:0]          b_top,
    input  logic [5:0]          pa_top,
    output srt_div_pkg::digit_t digit
);

    srt_div_pkg::thresh_row_t row;
    logic signed [5:0] pa_s;

    assign row = srt_div_pkg::div_thresh[b_top];
    assign pa_s = pa_top;

    // values outside a row land on the outer digits
    always_comb begin
        if (pa_s < row[0]) begin
            digit = srt_div_pkg::digit_m2;
        end else if (pa_s < row[1]) begin
            digit = srt_div_pkg::digit_m1;
        end else if (pa_s < row[2]) begin
            digit = srt_div_pkg::digit_z;
        end else if (pa_s < row[3]) begin
            digit = srt_div_pkg::digit_p1;
        end else begin
            digit = srt_div_pkg::digit_p2;
        end
    end

endmodule

// File: rtl/srt_div_core.sv
// unsigned SRT divider pipeline, one division per clock, result and ok leave the same register
`timescale 1ns/1ps

module srt_div_core (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush,
    input  logic                   valid,
    input  srt_div_pkg::word_t     a,
    input  srt_div_pkg::word_t     b,
    input  srt_div_pkg::div_sign_t sign_in,
    output srt_div_pkg::dword_t    result,
    output srt_div_pkg::div_sign_t sign_out,
    output logic                   ok
);

    logic in_valid;
    srt_div_pkg::word_t in_a;
    srt_div_pkg::word_t in_b;
    srt_div_pkg::div_sign_t in_sign;

    srt_div_pkg::div_stage_t [srt_div_pkg::num_stages+1:1] stage_q;
    srt_div_pkg::div_stage_t [srt_div_pkg::num_stages:0] stage_d;
    srt_div_pkg::div_stage_t last;

    srt_div_pkg::word_t rem_sum;
    srt_div_pkg::word_t rem_fix;
    srt_div_pkg::word_t quo_fix;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            in_valid <= 1'b0;
            in_a <= '0;
            in_b <= '0;
            in_sign <= '0;
            stage_q <= '0;
            result <= '0;
            sign_out <= '0;
            ok <= 1'b0;
        end else begin
            in_valid <= valid;
            in_a <= a;
            in_b <= b;
            in_sign <= sign_in;
            stage_q <= stage_d;
            result <= {rem_fix, quo_fix};
            sign_out <= last.sign;
            ok <= last.ok;
        end
    end

    srt_normalize normalize_i (
        .a     (in_a),
        .b     (in_b),
        .valid (in_valid),
        .sign  (in_sign),
        .rec   (stage_d[0])
    );

    for (genvar g = 1; g <= srt_div_pkg::num_stages; g++) begin : g_stage
        srt_stage stage_i (
            .rec_in  (stage_q[g]),
            .rec_out (stage_d[g])
        );
    end

    assign last = stage_q[srt_div_pkg::num_stages+1];

    // negative final remainder, add the divisor back and take one off the quotient
    always_comb begin
        if (last.pa[srt_div_pkg::pa_w-1]) begin
            rem_sum = last.pa[srt_div_pkg::pa_w-2:srt_div_pkg::word_w] + last.b;
            quo_fix = last.q - 1'b1;
        end else begin
            rem_sum = last.pa[srt_div_pkg::pa_w-2:srt_div_pkg::word_w];
            quo_fix = last.q;
        end
    end

    // undo the normalization on the remainder
    assign rem_fix = rem_sum >> last.shift;

endmodule

// File: rtl/srt_div_pkg.sv
// shared widths, digit encoding, selection thresholds and stage records for the SRT divider RTL
package srt_div_pkg;

    localparam int word_w = 32;
    localparam int pa_w = 2 * word_w + 1;
    localparam int num_stages = 16;
    // input register, normalizer into stage 1, 16 stages, output register
    localparam int latency = num_stages + 2;

    typedef logic [word_w-1:0] word_t;
    typedef logic [2*word_w-1:0] dword_t;
    typedef logic [4:0] shift_t;

    // two's complement codes, so a digit can be sign extended and added directly
    typedef enum logic [2:0] {
        digit_m2 = 3'b110,
        digit_m1 = 3'b111,
        digit_z  = 3'b000,
        digit_p1 = 3'b001,
        digit_p2 = 3'b010
    } digit_t;

    typedef logic signed [5:0] thresh_t;

    // lowest remainder top value for digits -1, 0, +1, +2
    typedef thresh_t [0:3] thresh_row_t;

    // row index is divisor bits 30:28, remainder top is bits 64:59
    localparam thresh_row_t div_thresh [0:7] = '{
        '{-6'sd6,  -6'sd2, 6'sd2, 6'sd6},
        '{-6'sd7,  -6'sd2, 6'sd3, 6'sd7},
        '{-6'sd8,  -6'sd2, 6'sd3, 6'sd8},
        '{-6'sd8,  -6'sd2, 6'sd3, 6'sd9},
        '{-6'sd9,  -6'sd3, 6'sd4, 6'sd10},
        '{-6'sd10, -6'sd3, 6'sd4, 6'sd10},
        '{-6'sd10, -6'sd3, 6'sd4, 6'sd11},
        '{-6'sd11, -6'sd3, 6'sd5, 6'sd12}
    };

    typedef struct packed {
        logic neg_q;
        logic neg_r;
    } div_sign_t;

    // one division in flight
    typedef struct packed {
        logic            ok;
        div_sign_t       sign;
        logic [pa_w-1:0] pa;
        word_t           b;
        shift_t          shift;
        word_t           q;
    } div_stage_t;

endpackage

// File: rtl/srt_divider.sv
// signed and unsigned 32-bit SRT divider top, hilo holds the remainder high and quotient low
`timescale 1ns/1ps

module srt_divider (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                valid,
    input  logic                is_signed,
    input  srt_div_pkg::word_t  a,
    input  srt_div_pkg::word_t  b,
    output srt_div_pkg::dword_t hilo,
    output logic                ok
);

    logic a_neg;
    logic b_neg;
    srt_div_pkg::word_t a_mag;
    srt_div_pkg::word_t b_mag;
    srt_div_pkg::div_sign_t sign_in;
    srt_div_pkg::div_sign_t sign_out;
    srt_div_pkg::dword_t result;

    assign a_neg = is_signed & a[srt_div_pkg::word_w-1];
    assign b_neg = is_signed & b[srt_div_pkg::word_w-1];

    // most negative operand maps onto its own unsigned magnitude
    assign a_mag = a_neg ? -a : a;
    assign b_mag = b_neg ? -b : b;

    // truncation toward zero, remainder follows the dividend
    assign sign_in.neg_q = a_neg ^ b_neg;
    assign sign_in.neg_r = a_neg;

    srt_div_core core_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .valid    (valid),
        .a        (a_mag),
        .b        (b_mag),
        .sign_in  (sign_in),
        .result   (result),
        .sign_out (sign_out),
        .ok       (ok)
    );

    assign hilo[srt_div_pkg::word_w-1:0] = sign_out.neg_q
        ? -result[srt_div_pkg::word_w-1:0]
        : result[srt_div_pkg::word_w-1:0];
    assign hilo[2*srt_div_pkg::word_w-1:srt_div_pkg::word_w] = sign_out.neg_r
        ? -result[2*srt_div_pkg::word_w-1:srt_div_pkg::word_w]
        : result[2*srt_div_pkg::word_w-1:srt_div_pkg::word_w];

endmodule

// File: rtl/srt_normalize.sv
// divider front end, aligns the divisor's leading one to bit 31 and builds the first stage record
`timescale 1ns/1ps

module srt_normalize (
    input  srt_div_pkg::word_t      a,
    input  srt_div_pkg::word_t      b,
    input  logic                    valid,
    input  srt_div_pkg::div_sign_t  sign,
    output srt_div_pkg::div_stage_t rec
);

    srt_div_pkg::shift_t shift;
    srt_div_pkg::word_t b_norm;
    logic [srt_div_pkg::pa_w-1:0] pa_shift;
    logic fold;

    // highest set bit wins
    always_comb begin
        shift = '0;
        for (int i = 0; i < srt_div_pkg::word_w; i++) begin
            if (b[i]) begin
                shift = srt_div_pkg::shift_t'(srt_div_pkg::word_w - 1 - i);
            end
        end
    end

    assign b_norm = b << shift;
    assign pa_shift = {{(srt_div_pkg::word_w + 1){1'b0}}, a} << shift;

    // only b == 1 starts at or above half the divisor
    // taking one divisor off moves the quotient by 2^32, outside the result word
    assign fold = pa_shift[2*srt_div_pkg::word_w-1:srt_div_pkg::word_w]
                  >= {1'b0, b_norm[srt_div_pkg::word_w-1:1]};

    always_comb begin
        rec = '0;
        rec.ok = valid;
        rec.sign = sign;
        // zero divisor keeps an all-zero payload
        if (b != '0) begin
            rec.b = b_norm;
            rec.shift = shift;
            rec.pa = pa_shift;
            if (fold) begin
                rec.pa[srt_div_pkg::pa_w-1:srt_div_pkg::word_w] =
                    pa_shift[srt_div_pkg::pa_w-1:srt_div_pkg::word_w] - {1'b0, b_norm};
            end
        end
    end

endmodule

// File: rtl/srt_stage.sv
// one radix-4 SRT iteration, retires two quotient bits per pass
`timescale 1ns/1ps

module srt_stage (
    input  srt_div_pkg::div_stage_t rec_in,
    output srt_div_pkg::div_stage_t rec_out
);

    srt_div_pkg::digit_t digit;
    logic [srt_div_pkg::word_w:0] rem_x4;
    logic [srt_div_pkg::word_w:0] b_x1;
    logic [srt_div_pkg::word_w:0] b_x2;

    srt_digit_select digit_select_i (
        .b_top  (rec_in.b[srt_div_pkg::word_w-2 -: 3]),
        .pa_top (rec_in.pa[srt_div_pkg::pa_w-1 -: 6]),
        .digit  (digit)
    );

    // remainder times four, wraps back into range after the subtract
    assign rem_x4 = rec_in.pa[srt_div_pkg::pa_w-3 -: srt_div_pkg::word_w+1];
    assign b_x1 = {1'b0, rec_in.b};
    assign b_x2 = {rec_in.b, 1'b0};

    always_comb begin
        rec_out = rec_in;
        rec_out.pa[srt_div_pkg::word_w-1:0] = {rec_in.pa[srt_div_pkg::word_w-3:0], 2'b00};
        // negative digits borrow from the upper quotient bits
        rec_out.q = {rec_in.q[srt_div_pkg::word_w-3:0], 2'b00}
                    + {{(srt_div_pkg::word_w - 3){digit[2]}}, digit};
        case (digit)
            srt_div_pkg::digit_p2: begin
                rec_out.pa[srt_div_pkg::pa_w-1:srt_div_pkg::word_w] = rem_x4 - b_x2;
            end
            srt_div_pkg::digit_p1: begin
                rec_out.pa[srt_div_pkg::pa_w-1:srt_div_pkg::word_w] = rem_x4 - b_x1;
            end
            srt_div_pkg::digit_m1: begin
                rec_out.pa[srt_div_pkg::pa_w-1:srt_div_pkg::word_w] = rem_x4 + b_x1;
            end
            srt_div_pkg::digit_m2: begin
                rec_out.pa[srt_div_pkg::pa_w-1:srt_div_pkg::word_w] = rem_x4 + b_x2;
            end
            default: begin
                rec_out.pa[srt_div_pkg::pa_w-1:srt_div_pkg::word_w] = rem_x4;
            end
        endcase
    end

endmodule

// File: tb/srt_divider_checker.sv
// assertion module bound to the divider top, models each division and checks ok timing and hilo
`timescale 1ns/1ps

module srt_divider_checker (
    input logic                clk,
    input logic                rst_n,
    input logic                flush,
    input logic                valid,
    input logic                is_signed,
    input srt_div_pkg::word_t  a,
    input srt_div_pkg::word_t  b,
    input srt_div_pkg::dword_t hilo,
    input logic                ok
);

    localparam int lat = srt_div_pkg::latency;

    int unsigned fail_count = 0;

    // expected results in flight, slot lat lines up with the DUT output register
    logic [lat:0] exp_ok;
    srt_div_pkg::dword_t exp_hilo [0:lat];

    // remainder high, quotient low
    function automatic srt_div_pkg::dword_t expected_hilo(
        input srt_div_pkg::word_t op_a,
        input srt_div_pkg::word_t op_b,
        input logic               sgn
    );
        srt_div_pkg::word_t q;
        srt_div_pkg::word_t r;
        if (op_b == '0) begin
            q = '0;
            r = '0;
        end else if (!sgn) begin
            q = op_a / op_b;
            r = op_a % op_b;
        end else if (op_a == 32'h8000_0000 && op_b == 32'hffff_ffff) begin
            // quotient overflows and wraps to the most negative value
            q = 32'h8000_0000;
            r = '0;
        end else begin
            q = $signed(op_a) / $signed(op_b);
            r = $signed(op_a) % $signed(op_b);
        end
        return {r, q};
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            exp_ok <= '0;
            for (int i = 0; i <= lat; i++) begin
                exp_hilo[i] <= '0;
            end
        end else begin
            exp_ok <= {exp_ok[lat-1:0], valid};
            exp_hilo[0] <= expected_hilo(a, b, is_signed);
            for (int i = 1; i <= lat; i++) begin
                exp_hilo[i] <= exp_hilo[i-1];
            end
        end
    end

    ok_after_reset: assert property (@(posedge clk) !rst_n |=> !ok)
        else begin
            fail_count++;
            $error("ok is high during or right after reset");
        end

    ok_after_flush: assert property (@(posedge clk) disable iff (!rst_n) flush |=> !ok)
        else begin
            fail_count++;
            $error("ok is high in the cycle after a flush");
        end

    ok_has_division: assert property (@(posedge clk) disable iff (!rst_n) ok |-> exp_ok[lat])
        else begin
            fail_count++;
            $error("ok pulse without a division issued %0d cycles before", lat);
        end

    ok_on_time: assert property (@(posedge clk) disable iff (!rst_n) exp_ok[lat] |-> ok)
        else begin
            fail_count++;
            $error("no ok pulse %0d cycles after a division was issued", lat);
        end

    hilo_value: assert property (@(posedge clk) disable iff (!rst_n) ok |-> hilo == exp_hilo[lat])
        else begin
            fail_count++;
            $error("Fail hilo expected %h got %h", $sampled(exp_hilo[lat]), $sampled(hilo));
        end

endmodule

bind srt_divider srt_divider_checker checker_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .valid     (valid),
    .is_signed (is_signed),
    .a         (a),
    .b         (b),
    .hilo      (hilo),
    .ok        (ok)
);

// File: tb/tb_clock.sv
// free-running testbench clock, instantiated once by the testbench top
`timescale 1ns/1ps

module tb_clock #(
    parameter real period = 10.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2.0) clk = ~clk;
        end
    end

endmodule

// File: tb/tb_srt_divider.sv
// testbench top for the SRT divider, drives all test sequences while the bound checker compares
`timescale 1ns/1ps

module tb_srt_divider;

    localparam int n_sweep = 32;
    localparam int n_unsigned = 110;
    localparam int n_corner = 10;
    localparam int n_signed = 130;
    localparam int n_zero = 8;
    localparam int n_flush = 16;
    localparam int n_divisions = n_sweep + n_unsigned + n_corner + n_signed + n_zero + n_flush;
    localparam int watchdog_cycles = n_divisions + 4 * srt_div_pkg::latency + 50;

    logic clk;
    logic rst_n;
    logic flush;
    logic valid;
    logic is_signed;
    srt_div_pkg::word_t a;
    srt_div_pkg::word_t b;
    srt_div_pkg::dword_t hilo;
    logic ok;

    integer seed = 32'hea25;

    tb_clock #(.period(10.0)) clock_i (.clk(clk));

    srt_divider srt_divider_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .valid     (valid),
        .is_signed (is_signed),
        .a         (a),
        .b         (b),
        .hilo      (hilo),
        .ok        (ok)
    );

    task automatic fail_run(input string reason);
        $display("Something failed");
        $fatal(1, "%s", reason);
    endtask

    // inputs change 1 ns after the rising edge
    task automatic drive(input logic v, input logic f, input logic sgn,
                         input srt_div_pkg::word_t op_a, input srt_div_pkg::word_t op_b);
        @(posedge clk);
        #1;
        valid = v;
        flush = f;
        is_signed = sgn;
        a = op_a;
        b = op_b;
    endtask

    task automatic issue(input srt_div_pkg::word_t op_a, input srt_div_pkg::word_t op_b,
                         input logic sgn);
        drive(1'b1, 1'b0, sgn, op_a, op_b);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            drive(1'b0, 1'b0, 1'b0, '0, '0);
        end
    endtask

    // divisor leading one at every bit position
    task automatic leading_one_sweep();
        srt_div_pkg::word_t mask;
        srt_div_pkg::word_t low;
        for (int pos = 0; pos < n_sweep; pos++) begin
            mask = (32'h1 << pos) - 32'h1;
            low = $random(seed);
            issue($random(seed), (low & mask) | (32'h1 << pos), 1'b0);
        end
    endtask

    task automatic unsigned_random(input int count);
        srt_div_pkg::word_t op_b;
        int shift;
        repeat (count) begin
            op_b = $random(seed);
            shift = $random(seed) & 31;
            issue($random(seed), op_b >> shift, 1'b0);
        end
    endtask

    task automatic corner_cases();
        issue(32'h8000_0000, 32'hffff_ffff, 1'b1);
        issue(32'h8000_0000, 32'h0000_0001, 1'b1);
        issue(32'h8000_0000, 32'h8000_0000, 1'b1);
        issue(32'hffff_ffff, 32'h8000_0000, 1'b1);
        issue(32'h8000_0000, 32'hffff_ffff, 1'b0);
        issue(32'hffff_ffff, 32'h0000_0001, 1'b0);
        issue(32'hffff_ffff, 32'hffff_ffff, 1'b0);
        issue(32'h0000_0000, 32'h1234_5678, 1'b1);
        issue(32'h0000_0007, 32'hffff_fffd, 1'b1);
        issue(32'hffff_fff9, 32'h0000_0003, 1'b1);
    endtask

    // low two bits of i pick the operand signs, every third one runs unsigned
    task automatic mixed_sign_random(input int count);
        srt_div_pkg::word_t mag_a;
        srt_div_pkg::word_t mag_b;
        srt_div_pkg::word_t op_a;
        srt_div_pkg::word_t op_b;
        for (int i = 0; i < count; i++) begin
            mag_a = $random(seed) & 32'h7fff_ffff;
            mag_b = ($random(seed) & 32'h7fff_ffff) >> ($random(seed) & 31);
            mag_b = mag_b | 32'h1;
            op_a = i[0] ? -mag_a : mag_a;
            op_b = i[1] ? -mag_b : mag_b;
            issue(op_a, op_b, (i % 3) != 2);
        end
    endtask

    task automatic zero_divisor();
        for (int i = 0; i < n_zero; i++) begin
            issue((i < 2) ? 32'h8000_0000 : $random(seed), '0, i[0]);
        end
    endtask

    task automatic flush_in_flight();
        repeat (10) begin
            issue($random(seed), $random(seed), 1'b0);
        end
        drive(1'b0, 1'b1, 1'b0, '0, '0);
        // first division right after the flush edge
        repeat (n_flush - 10) begin
            issue($random(seed), $random(seed), 1'b1);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        flush = 1'b0;
        valid = 1'b0;
        is_signed = 1'b0;
        a = '0;
        b = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle(2);
        leading_one_sweep();
        unsigned_random(n_unsigned);
        corner_cases();
        mixed_sign_random(n_signed);
        zero_divisor();
        flush_in_flight();
        idle(srt_div_pkg::latency + 3);
        if (srt_divider_i.checker_i.fail_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            fail_run("checker assertions failed during the run");
        end
    end

    initial begin
        wait (srt_divider_i.checker_i.fail_count != 0);
        fail_run("an assertion in the checker failed");
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        fail_run("watchdog expired before the tests finished");
    end

endmodule

// File: vlog.f
rtl/srt_div_pkg.sv
rtl/srt_normalize.sv
rtl/srt_digit_select.sv
rtl/srt_stage.sv
rtl/srt_div_core.sv
rtl/srt_divider.sv
tb/tb_clock.sv
tb/srt_divider_checker.sv
tb/tb_srt_divider.sv
